/* Makefile */
SIM        = verilator
TOP        = ecc_codec_tb
RTL_TOP    = ecc_codec
FILELIST   = ecc_codec.f
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
OBJ_DIR    = obj_dir
PASS_MSG   = Test OK

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		src/ecc_pkg.sv src/syndrome_if.sv src/hamming_encoder.sv \
		src/syndrome_calc.sv src/error_corrector.sv src/ecc_codec.sv

clean:
	rm -rf $(OBJ_DIR)

/* ecc_codec.f */
src/ecc_pkg.sv
src/syndrome_if.sv
src/hamming_encoder.sv
src/syndrome_calc.sv
src/error_corrector.sv
src/ecc_codec.sv
verif/ecc_codec_props.sv
verif/ecc_codec_tb.sv

/* src/ecc_codec.sv */
`timescale 1ns/1ns

module ecc_codec (
    input  logic                 clk,
    input  logic                 rst,
    // encode side
    input  logic                 enc_valid,
    input  ecc_pkg::data_t       enc_data,
    output logic                 code_valid,
    output ecc_pkg::code_t       code_word,
    // decode side
    input  logic                 dec_in_valid,
    input  ecc_pkg::code_t       dec_in_word,
    output logic                 dec_valid,
    output ecc_pkg::data_t       dec_data,
    output ecc_pkg::ecc_status_e dec_status
);

    // between the two decoder stages
    syndrome_if syn_bus ();

    // encode path, 2 cycles
    hamming_encoder u_encoder (
        .clk        (clk),
        .rst        (rst),
        .enc_valid  (enc_valid),
        .enc_data   (enc_data),
        .code_valid (code_valid),
        .code_word  (code_word)
    );

    // decode stage 1
    syndrome_calc u_syndrome (
        .clk      (clk),
        .rst      (rst),
        .in_valid (dec_in_valid),
        .in_word  (dec_in_word),
        .syn      (syn_bus.producer)
    );

    // decode stage 2
    error_corrector u_corrector (
        .clk        (clk),
        .rst        (rst),
        .syn        (syn_bus.consumer),
        .out_valid  (dec_valid),
        .out_data   (dec_data),
        .out_status (dec_status)
    );

endmodule

/* src/ecc_pkg.sv */
package ecc_pkg;

    // extended hamming (8,4) code sizes
    localparam int data_bits  = 4;
    localparam int check_bits = 3;
    localparam int code_bits  = 8;

    typedef logic [data_bits-1:0]  data_t;
    typedef logic [code_bits-1:0]  code_t;
    typedef logic [check_bits-1:0] syndrome_t;

    // one row per check bit, a set bit selects that data bit
    // check 0 <- d0 d1 d3, check 1 <- d0 d2 d3, check 2 <- d1 d2 d3
    localparam logic [check_bits-1:0][data_bits-1:0] check_mask = {
        4'b1110,
        4'b1101,
        4'b1011
    };

    // codeword layout: data in 7..4, overall parity in 3, checks in 2..0
    localparam int parity_pos = 3;
    localparam int data_lsb   = 4;

    // decode result
    typedef enum logic [1:0] {
        status_clean         = 2'd0,
        status_corrected     = 2'd1,
        status_uncorrectable = 2'd2
    } ecc_status_e;

    // check bits of a nibble, shared by the encoder and the syndrome stage
    function automatic syndrome_t calc_check(data_t d);
        syndrome_t c;
        for (int i = 0; i < check_bits; i++) begin
            c[i] = ^(d & check_mask[i]);
        end
        return c;
    endfunction

endpackage

/* src/error_corrector.sv */
`timescale 1ns/1ns

module error_corrector (
    input  logic                 clk,
    input  logic                 rst,
    syndrome_if.consumer         syn,
    output logic                 out_valid,
    output ecc_pkg::data_t       out_data,
    output ecc_pkg::ecc_status_e out_status
);

    // uncorrected data field from the received word
    ecc_pkg::data_t       rx_data;
    // one-hot data bit whose column matches the syndrome
    ecc_pkg::data_t       flip;
    // next output values
    ecc_pkg::data_t       data_d;
    ecc_pkg::ecc_status_e status_d;

    always_comb begin
        rx_data = syn.word[ecc_pkg::data_lsb +: ecc_pkg::data_bits];
    end

    // column of data bit k: bit i set when check i covers k
    // check columns are one-hot, so never match a data column
    always_comb begin
        ecc_pkg::syndrome_t col;
        col  = '0;
        flip = '0;
        for (int k = 0; k < ecc_pkg::data_bits; k++) begin
            for (int i = 0; i < ecc_pkg::check_bits; i++) begin
                col[i] = ecc_pkg::check_mask[i][k];
            end
            flip[k] = (col == syn.syndrome);
        end
    end

    // classify per syndrome and overall parity
    always_comb begin
        data_d   = rx_data;
        status_d = ecc_pkg::status_clean;
        if (syn.parity_err) begin
            // odd error count, assume single
            status_d = ecc_pkg::status_corrected;
            // s == 0: parity bit itself flipped, data ok
            // check column: data ok, flip stays zero
            if (syn.syndrome != '0) begin
                data_d = rx_data ^ flip;
            end
        end else if (syn.syndrome != '0) begin
            // even count with nonzero syndrome, double error
            // data passed through uncorrected
            status_d = ecc_pkg::status_uncorrectable;
        end
    end

    // output regs
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            out_data   <= '0;
            out_status <= ecc_pkg::status_clean;
        end else begin
            out_valid  <= syn.valid;
            out_data   <= data_d;
            out_status <= status_d;
        end
    end

endmodule

/* src/hamming_encoder.sv */
`timescale 1ns/1ns

module hamming_encoder (
    input  logic           clk,
    input  logic           rst,
    input  logic           enc_valid,
    input  ecc_pkg::data_t enc_data,
    output logic           code_valid,
    output ecc_pkg::code_t code_word
);

    // stage 1 word: data and checks, parity slot still zero
    ecc_pkg::code_t s1_word_d;
    ecc_pkg::code_t s1_word;
    logic           s1_valid;

    // stage 2 word with the overall parity filled in
    ecc_pkg::code_t s2_word_d;

    // stage 1 comb
    always_comb begin
        s1_word_d = '0;
        // data field
        s1_word_d[ecc_pkg::data_lsb +: ecc_pkg::data_bits] = enc_data;
        // check bits from the masks
        s1_word_d[ecc_pkg::check_bits-1:0] = ecc_pkg::calc_check(enc_data);
        // parity slot left at 0 here
        s1_word_d[ecc_pkg::parity_pos] = 1'b0;
    end

    // stage 1 regs
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_word  <= '0;
        end else begin
            s1_valid <= enc_valid;
            s1_word  <= s1_word_d;
        end
    end

    // stage 2 comb
    // slot 3 is zero, so reducing the whole word
    // gives the xor of the other seven bits
    always_comb begin
        s2_word_d = s1_word;
        s2_word_d[ecc_pkg::parity_pos] = ^s1_word;
    end

    // stage 2 regs, output side
    always_ff @(posedge clk) begin
        if (rst) begin
            code_valid <= 1'b0;
            code_word  <= '0;
        end else begin
            code_valid <= s1_valid;
            code_word  <= s2_word_d;
        end
    end

endmodule

/* src/syndrome_calc.sv */
`timescale 1ns/1ns

module syndrome_calc (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  ecc_pkg::code_t in_word,
    syndrome_if.producer   syn
);

    // received fields
    ecc_pkg::data_t     rx_data;
    ecc_pkg::syndrome_t rx_check;

    // next values for the interface regs
    ecc_pkg::syndrome_t syndrome_d;
    logic               parity_err_d;

    // split the received word
    always_comb begin
        rx_data  = in_word[ecc_pkg::data_lsb +: ecc_pkg::data_bits];
        rx_check = in_word[ecc_pkg::check_bits-1:0];
    end

    // recompute checks from the data field and compare
    // a zero syndrome means data and checks agree
    always_comb begin
        syndrome_d = ecc_pkg::calc_check(rx_data) ^ rx_check;
    end

    // overall parity over all eight bits incl. bit 3
    // nonzero => odd number of flipped bits
    always_comb begin
        parity_err_d = ^in_word;
    end

    // register everything together so the
    // corrector sees word and syndrome aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            syn.valid      <= 1'b0;
            syn.word       <= '0;
            syn.syndrome   <= '0;
            syn.parity_err <= 1'b0;
        end else begin
            syn.valid      <= in_valid;
            syn.word       <= in_word;
            syn.syndrome   <= syndrome_d;
            syn.parity_err <= parity_err_d;
        end
    end

endmodule

/* src/syndrome_if.sv */
`timescale 1ns/1ns

interface syndrome_if;

    // one item per cycle with valid high, no back-pressure
    logic              valid;
    // received codeword, carried along for the correction stage
    ecc_pkg::code_t    word;
    // recomputed checks xor received checks
    ecc_pkg::syndrome_t syndrome;
    // xor of all eight received bits
    logic              parity_err;

    // syndrome stage drives
    modport producer (
        output valid,
        output word,
        output syndrome,
        output parity_err
    );

    // correction stage reads
    modport consumer (
        input valid,
        input word,
        input syndrome,
        input parity_err
    );

endinterface

/* verif/ecc_codec_props.sv */
`timescale 1ns/1ns

module ecc_codec_props (
    input logic clk,
    input logic rst,
    input logic enc_valid,
    input logic code_valid,
    input logic dec_in_valid,
    input logic dec_valid
);

    // encoder, two register stages
    enc_latency: assert property (
        @(posedge clk) disable iff (rst)
        enc_valid |-> ##2 code_valid
    ) else $error("code_valid missing two cycles after enc_valid");

    // decoder, syndrome stage then corrector
    dec_latency: assert property (
        @(posedge clk) disable iff (rst)
        dec_in_valid |-> ##2 dec_valid
    ) else $error("dec_valid missing two cycles after dec_in_valid");

    // no output strobe without an input two cycles back
    enc_no_spurious: assert property (
        @(posedge clk) disable iff (rst)
        code_valid |-> $past(enc_valid, 2)
    ) else $error("code_valid without enc_valid two cycles earlier");

    dec_no_spurious: assert property (
        @(posedge clk) disable iff (rst)
        dec_valid |-> $past(dec_in_valid, 2)
    ) else $error("dec_valid without dec_in_valid two cycles earlier");

    // both valids cleared by reset
    reset_clears: assert property (
        @(posedge clk)
        rst |=> (!code_valid && !dec_valid)
    ) else $error("output valid high in the cycle after reset");

endmodule

bind ecc_codec ecc_codec_props u_props (
    .clk          (clk),
    .rst          (rst),
    .enc_valid    (enc_valid),
    .code_valid   (code_valid),
    .dec_in_valid (dec_in_valid),
    .dec_valid    (dec_valid)
);

/* verif/ecc_codec_tb.sv */
`timescale 1ns/1ns

module ecc_codec_tb;

    // items per test
    localparam int n_enc    = 48;
    localparam int n_clean  = 48;
    localparam int n_single = 96;
    localparam int n_double = 96;
    localparam int n_tput   = 200;
    // throughput cycles may strobe both paths
    localparam int total_strobes = n_enc + n_clean + n_single + n_double + 2 * n_tput;
    localparam int cycle_limit   = total_strobes * 2 + 100;
    // both paths are two stages deep, two spare cycles on top
    localparam int drain_limit   = 4;

    logic                 clk;
    logic                 rst;
    logic                 enc_valid;
    ecc_pkg::data_t       enc_data;
    logic                 code_valid;
    ecc_pkg::code_t       code_word;
    logic                 dec_in_valid;
    ecc_pkg::code_t       dec_in_word;
    logic                 dec_valid;
    ecc_pkg::data_t       dec_data;
    ecc_pkg::ecc_status_e dec_status;

    // expected results, pushed at the input strobe
    ecc_pkg::code_t       exp_code_q[$];
    ecc_pkg::data_t       exp_data_q[$];
    ecc_pkg::ecc_status_e exp_status_q[$];

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests;
    int          cycles;

    ecc_codec uut (
        .clk          (clk),
        .rst          (rst),
        .enc_valid    (enc_valid),
        .enc_data     (enc_data),
        .code_valid   (code_valid),
        .code_word    (code_word),
        .dec_in_valid (dec_in_valid),
        .dec_in_word  (dec_in_word),
        .dec_valid    (dec_valid),
        .dec_data     (dec_data),
        .dec_status   (dec_status)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // second error position, never equal to the first
    function automatic logic [2:0] other_pos(logic [2:0] a);
        logic [2:0] r;
        r = 3'd0;
        while (r == 3'd0) begin
            r = 3'(rand_bits(3));
        end
        return a ^ r;
    endfunction

    // reference encoder: data 7..4, parity 3, checks 2..0
    function automatic ecc_pkg::code_t model_encode(ecc_pkg::data_t d);
        logic [2:0] c;
        c[0] = d[0] ^ d[1] ^ d[3];
        c[1] = d[0] ^ d[2] ^ d[3];
        c[2] = d[1] ^ d[2] ^ d[3];
        return {d, ^{d, c}, c};
    endfunction

    // reference decoder
    function automatic void model_decode(input ecc_pkg::code_t w,
                                         output ecc_pkg::data_t d,
                                         output ecc_pkg::ecc_status_e st);
        logic [2:0] s;
        logic       p;
        s[0] = w[4] ^ w[5] ^ w[7] ^ w[0];
        s[1] = w[4] ^ w[6] ^ w[7] ^ w[1];
        s[2] = w[5] ^ w[6] ^ w[7] ^ w[2];
        p    = ^w;
        d    = w[7:4];
        st   = ecc_pkg::status_clean;
        if (p) begin
            st = ecc_pkg::status_corrected;
            // data columns; zero or one-hot s leaves data alone
            case (s)
                3'b011:  d[0] = ~d[0];
                3'b101:  d[1] = ~d[1];
                3'b110:  d[2] = ~d[2];
                3'b111:  d[3] = ~d[3];
                default: d = w[7:4];
            endcase
        end else if (s != 3'b000) begin
            st = ecc_pkg::status_uncorrectable;
        end
    endfunction

    task automatic check_code(string name, ecc_pkg::code_t exp, ecc_pkg::code_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_data(string name, ecc_pkg::data_t exp, ecc_pkg::data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_status(string name, ecc_pkg::ecc_status_e exp,
                                ecc_pkg::ecc_status_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    // to the next drive point, 2 ns past the edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_enc(logic fire, ecc_pkg::data_t d);
        enc_valid = fire;
        enc_data  = d;
        if (fire) begin
            exp_code_q.push_back(model_encode(d));
        end
    endtask

    task automatic drive_dec(logic fire, ecc_pkg::code_t w, ecc_pkg::data_t exp_d,
                             ecc_pkg::ecc_status_e exp_st);
        dec_in_valid = fire;
        dec_in_word  = w;
        if (fire) begin
            exp_data_q.push_back(exp_d);
            exp_status_q.push_back(exp_st);
        end
    endtask

    // idle inputs, then wait for every queued result or give up
    task automatic wait_drain();
        int n;
        drive_enc(1'b0, '0);
        drive_dec(1'b0, '0, '0, ecc_pkg::status_clean);
        n = 0;
        while ((exp_code_q.size() != 0 || exp_data_q.size() != 0) && n < drain_limit) begin
            step();
            n++;
        end
        step();
        if (exp_code_q.size() != 0 || exp_data_q.size() != 0) begin
            errors++;
            $display("%0d codewords and %0d decode results never came out",
                     exp_code_q.size(), exp_data_q.size());
            // next test starts from empty queues
            exp_code_q.delete();
            exp_data_q.delete();
            exp_status_q.delete();
        end
    endtask

    task automatic end_test(string name, int err_before);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - err_before);
    endtask

    // output side, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && code_valid) begin
            if (exp_code_q.size() == 0) begin
                errors++;
                $display("code_valid came high with no codeword expected");
            end else begin
                check_code("code_word", exp_code_q.pop_front(), code_word);
            end
        end
        if (!rst && dec_valid) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("dec_valid came high with no decode result expected");
            end else begin
                check_data("dec_data", exp_data_q.pop_front(), dec_data);
                check_status("dec_status", exp_status_q.pop_front(), dec_status);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles with results still missing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // no strobe yet, both output valids must stay low
    task automatic run_idle();
        int e0;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checks++;
            if (code_valid !== 1'b0) begin
                errors++;
                $display("[ERROR] code_valid expected 0x0 got 0x%h", code_valid);
            end
            checks++;
            if (dec_valid !== 1'b0) begin
                errors++;
                $display("[ERROR] dec_valid expected 0x0 got 0x%h", dec_valid);
            end
        end
        step();
        end_test("idle after reset", e0);
    endtask

    task automatic run_encode();
        int e0;
        e0 = errors;
        for (int i = 0; i < n_enc; i++) begin
            drive_enc(1'b1, ecc_pkg::data_t'(rand_bits(4)));
            step();
        end
        wait_drain();
        end_test("encode", e0);
    endtask

    task automatic run_clean();
        ecc_pkg::data_t d;
        int             e0;
        e0 = errors;
        for (int i = 0; i < n_clean; i++) begin
            d = ecc_pkg::data_t'(rand_bits(4));
            drive_dec(1'b1, model_encode(d), d, ecc_pkg::status_clean);
            step();
        end
        wait_drain();
        end_test("clean decode", e0);
    endtask

    task automatic run_single();
        ecc_pkg::data_t d;
        logic [2:0]     pos;
        int             e0;
        e0 = errors;
        for (int i = 0; i < n_single; i++) begin
            d = ecc_pkg::data_t'(rand_bits(4));
            // first eight walk every position, bit 3 included
            pos = (i < 8) ? 3'(i) : 3'(rand_bits(3));
            drive_dec(1'b1, model_encode(d) ^ (8'b1 << pos), d, ecc_pkg::status_corrected);
            step();
        end
        wait_drain();
        end_test("single error correction", e0);
    endtask

    task automatic run_double();
        ecc_pkg::code_t w;
        logic [2:0]     pa;
        logic [2:0]     pb;
        int             e0;
        e0 = errors;
        for (int i = 0; i < n_double; i++) begin
            pa = 3'(rand_bits(3));
            pb = other_pos(pa);
            w  = model_encode(ecc_pkg::data_t'(rand_bits(4))) ^ (8'b1 << pa) ^ (8'b1 << pb);
            // data field comes back as received
            drive_dec(1'b1, w, w[7:4], ecc_pkg::status_uncorrectable);
            step();
        end
        wait_drain();
        end_test("double error detection", e0);
    endtask

    // back to back for the first half, random gaps after that
    task automatic run_throughput();
        ecc_pkg::code_t       w;
        ecc_pkg::data_t       md;
        ecc_pkg::ecc_status_e ms;
        logic                 fire_e;
        logic                 fire_d;
        logic [1:0]           kind;
        logic [2:0]           pa;
        int                   e0;
        e0 = errors;
        for (int i = 0; i < n_tput; i++) begin
            fire_e = (i < n_tput / 2) || (2'(rand_bits(2)) != 2'd0);
            fire_d = (i < n_tput / 2) || (2'(rand_bits(2)) != 2'd0);
            drive_enc(fire_e, ecc_pkg::data_t'(rand_bits(4)));
            // 0 clean, 1 single, 2..3 double
            w    = model_encode(ecc_pkg::data_t'(rand_bits(4)));
            kind = 2'(rand_bits(2));
            pa   = 3'(rand_bits(3));
            if (kind != 2'd0) begin
                w = w ^ (8'b1 << pa);
            end
            if (kind[1]) begin
                w = w ^ (8'b1 << other_pos(pa));
            end
            model_decode(w, md, ms);
            drive_dec(fire_d, w, md, ms);
            step();
        end
        wait_drain();
        end_test("throughput", e0);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        enc_valid    = 1'b0;
        enc_data     = '0;
        dec_in_valid = 1'b0;
        dec_in_word  = '0;
        lfsr_state   = 32'h3f29;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        cycles       = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        run_idle();
        run_encode();
        run_clean();
        run_single();
        run_double();
        run_throughput();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
